/* filelist.f */
verilog/trap_pkg.sv
verilog/bus_pkg.sv
verilog/trap_event_decoder.sv
verilog/first_trap_capture.sv
verilog/obi_bus_checker.sv
verilog/violation_reporter.sv
verilog/core_trap_monitor.sv
verif/core_trap_monitor_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core trap monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module core_trap_monitor_tb -f filelist.f -o core_trap_monitor_sim

if ! ./obj_dir/core_trap_monitor_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

/* verif/core_trap_monitor_tb.sv */
// Testbench for the core trap monitor driving trap, cause save and OBI bus scenarios
`timescale 1ns/1ps
`default_nettype none

module core_trap_monitor_tb;

  localparam int VW = trap_pkg::VIOL_W;

  // Violation bit positions: mismatch per kind first, then the bus rules
  localparam trap_pkg::viol_idx_t IDX_MIS_ECALL = 4'd1;
  localparam trap_pkg::viol_idx_t IDX_FETCH_MIS = 4'd4;
  localparam trap_pkg::viol_idx_t IDX_FETCH_BUF = 4'd5;
  localparam trap_pkg::viol_idx_t IDX_LOAD_BUF  = 4'd6;
  localparam trap_pkg::viol_idx_t IDX_ATOM_ORD  = 4'd8;

  logic                  clk;
  logic                  rst_ni;
  trap_pkg::wb_retire_t  wb;
  logic                  irq_ack;
  trap_pkg::cause_save_t cause;
  bus_pkg::instr_req_t   instr;
  bus_pkg::data_req_t    data_req;
  bus_pkg::data_rsp_t    data_rsp;
  trap_pkg::viol_t       viol;
  logic                  error;
  trap_pkg::viol_idx_t   first_viol;
  logic [VW-1:0]         viol_vec;
  logic                  quiet;
  int                    errors;
  int                    checks;
  integer                seed;
  trap_pkg::addr_t       pc_a;
  trap_pkg::addr_t       pc_b;

  core_trap_monitor #(
    .ATOMIC_EN (1'b1),
    .CNT_W     (2)
  ) core_trap_monitor_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_i         (wb),
    .irq_ack_i    (irq_ack),
    .cause_i      (cause),
    .instr_i      (instr),
    .data_req_i   (data_req),
    .data_rsp_i   (data_rsp),
    .viol_o       (viol),
    .error_o      (error),
    .first_viol_o (first_viol)
  );

  assign viol_vec = viol;

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Properties checked on every clock edge
  //////////////////////////////////////////////////////////////////////

  a_reset_clear : assert property (@(posedge clk)
    !rst_ni |-> (viol_vec == '0 && !error && first_viol == '0)
  ) else begin
    errors++;
    $display("[FAIL] viol_o=0x%h error_o=0x%h in reset", $sampled(viol_vec), $sampled(error));
  end

  // The summary flag is the OR of all violation bits
  a_error_or : assert property (@(posedge clk) error == (|viol_vec))
    else begin
      errors++;
      $display("[FAIL] error_o=0x%h viol_o=0x%h", $sampled(error), $sampled(viol_vec));
    end

  // Set bits never clear until the next reset
  a_sticky : assert property (@(posedge clk) disable iff (!rst_ni)
    1'b1 |=> ((viol_vec & $past(viol_vec)) == $past(viol_vec))
  ) else begin
    errors++;
    $display("[FAIL] viol_o=0x%h dropped bits of 0x%h", $sampled(viol_vec),
             $past(viol_vec));
  end

  a_first_set : assert property (@(posedge clk) disable iff (!rst_ni)
    error |-> viol_vec[first_viol]
  ) else begin
    errors++;
    $display("[FAIL] first_viol_o=0x%h viol_o=0x%h", $sampled(first_viol), $sampled(viol_vec));
  end

  // Phases with legal traffic only must keep the monitor silent
  a_quiet : assert property (@(posedge clk) disable iff (!rst_ni)
    quiet |-> (viol_vec == '0 && !error)
  ) else begin
    errors++;
    $display("[FAIL] viol_o=0x%h error_o=0x%h in a legal phase", $sampled(viol_vec),
             $sampled(error));
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [VW-1:0] vmask(input trap_pkg::viol_idx_t idx);
    logic [VW-1:0] m;
    m      = '0;
    m[idx] = 1'b1;
    return m;
  endfunction

  // mcause codes for illegal, ecall, ebreak and instruction fault in kind order
  function automatic logic [4:0] code_of_kind(input int k);
    case (k)
      0:       return 5'd2;
      1:       return 5'd11;
      2:       return 5'd3;
      default: return 5'd1;
    endcase
  endfunction

  task automatic apply_reset(input logic quiet_after);
    @(posedge clk);
    rst_ni   <= 1'b0;
    quiet    <= 1'b0;
    wb       <= '0;
    irq_ack  <= 1'b0;
    cause    <= '0;
    instr    <= '0;
    data_req <= '0;
    data_rsp <= '0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
    quiet  <= quiet_after;
  endtask

  task automatic retire(input trap_pkg::addr_t pc, input logic ill, input logic ecall,
                        input logic ebreak, input logic berr, input logic ack);
    trap_pkg::wb_retire_t w;
    w.valid   = 1'b1;
    w.pc      = pc;
    w.illegal = ill;
    w.ecall   = ecall;
    w.ebreak  = ebreak;
    w.bus_err = berr;
    @(posedge clk);
    wb      <= w;
    irq_ack <= ack;
    @(posedge clk);
    wb      <= '0;
    irq_ack <= 1'b0;
  endtask

  task automatic save_cause(input logic [4:0] code, input trap_pkg::addr_t mepc,
                            input logic irq);
    trap_pkg::cause_save_t c;
    c.save = 1'b1;
    c.irq  = irq;
    c.code = code;
    c.mepc = mepc;
    @(posedge clk);
    cause <= c;
    @(posedge clk);
    cause <= '0;
  endtask

  task automatic fetch(input logic [31:0] addr, input bus_pkg::memtype_t mt);
    bus_pkg::instr_req_t r;
    r.req     = 1'b1;
    r.addr    = addr;
    r.memtype = mt;
    @(posedge clk);
    instr <= r;
    @(posedge clk);
    instr <= '0;
  endtask

  // One read or atomic request held for a single cycle
  task automatic data_access(input logic gnt, input logic [5:0] atop,
                             input bus_pkg::memtype_t mt);
    bus_pkg::data_req_t r;
    r.req     = 1'b1;
    r.gnt     = gnt;
    r.we      = 1'b0;
    r.atop    = atop;
    r.memtype = mt;
    @(posedge clk);
    data_req <= r;
    @(posedge clk);
    data_req <= '0;
  endtask

  task automatic respond();
    @(posedge clk);
    data_rsp.rvalid <= 1'b1;
    @(posedge clk);
    data_rsp.rvalid <= 1'b0;
  endtask

  // Outputs are read on the falling edge where all flops have settled
  task automatic wait_for_bit(input trap_pkg::viol_idx_t idx, input int limit,
                              input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!viol_vec[idx] && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!viol_vec[idx]) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s", limit, what);
    end
  endtask

  task automatic expect_viol(input logic [VW-1:0] exp);
    @(negedge clk);
    checks++;
    assert (viol_vec == exp) else begin
      errors++;
      $display("[FAIL] viol_o got 0x%h expected 0x%h", viol_vec, exp);
    end
  endtask

  task automatic expect_first(input trap_pkg::viol_idx_t exp);
    @(negedge clk);
    checks++;
    assert (error && first_viol == exp) else begin
      errors++;
      $display("[FAIL] first_viol_o got 0x%h expected 0x%h", first_viol, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scenario sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk      = 1'b0;
    rst_ni   = 1'b0;
    wb       = '0;
    irq_ack  = 1'b0;
    cause    = '0;
    instr    = '0;
    data_req = '0;
    data_rsp = '0;
    quiet    = 1'b0;
    errors   = 0;
    checks   = 0;
    seed     = 32'h6390712e;

    // Matching mepc for every kind keeps the monitor silent
    apply_reset(1'b1);
    repeat (3) @(posedge clk);
    for (int k = 0; k < 4; k++) begin
      pc_a = trap_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
      retire(pc_a, k == 0, k == 1, k == 2, k == 3, 1'b0);
      save_cause(code_of_kind(k), pc_a, 1'b0);
    end
    repeat (3) @(posedge clk);
    expect_viol('0);

    // ECALL saved with a wrong mepc, later saves and a masked fault on top
    apply_reset(1'b0);
    pc_a = trap_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
    retire(pc_a, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    save_cause(5'd11, pc_a + 32'd4, 1'b0);
    wait_for_bit(IDX_MIS_ECALL, 2, "ECALL mepc mismatch");
    expect_first(IDX_MIS_ECALL);
    save_cause(5'd11, pc_a, 1'b0);
    pc_b = trap_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
    retire(pc_b, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    save_cause(5'd2, pc_b + 32'd8, 1'b0);
    repeat (3) @(posedge clk);
    expect_viol(vmask(IDX_MIS_ECALL));
    expect_first(IDX_MIS_ECALL);

    // Interrupt related saves and retires leave no record behind
    apply_reset(1'b1);
    pc_a = trap_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
    retire(pc_a, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    save_cause(5'd11, pc_a + 32'd4, 1'b1);
    save_cause(5'd11, pc_a, 1'b0);
    pc_b = trap_pkg::addr_t'($random(seed)) & 32'hFFFF_FFFC;
    retire(pc_b, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    save_cause(5'd3, pc_b + 32'd4, 1'b0);
    repeat (3) @(posedge clk);
    expect_viol('0);

    // Fetch and load attribute rules
    apply_reset(1'b0);
    fetch(32'h0000_1002, 2'b00);
    wait_for_bit(IDX_FETCH_MIS, 1, "fetch_misaligned");
    expect_first(IDX_FETCH_MIS);
    fetch(32'h0000_1004, 2'b01);
    wait_for_bit(IDX_FETCH_BUF, 1, "fetch_bufferable");
    data_access(1'b0, 6'd0, 2'b01);
    wait_for_bit(IDX_LOAD_BUF, 1, "load_bufferable");
    expect_viol(vmask(IDX_FETCH_MIS) | vmask(IDX_FETCH_BUF) | vmask(IDX_LOAD_BUF));

    // Atomic behind two outstanding loads
    apply_reset(1'b0);
    data_access(1'b1, 6'd0, 2'b00);
    data_access(1'b1, 6'd0, 2'b00);
    data_access(1'b0, 6'h21, 2'b00);
    wait_for_bit(IDX_ATOM_ORD, 1, "atomic_ordering behind loads");
    expect_viol(vmask(IDX_ATOM_ORD));
    respond();
    respond();

    // Fresh run, a legal atomic and then a response with nothing outstanding
    apply_reset(1'b1);
    data_access(1'b0, 6'h21, 2'b00);
    repeat (3) @(posedge clk);
    quiet <= 1'b0;
    respond();
    wait_for_bit(IDX_ATOM_ORD, 1, "atomic_ordering on underflow");
    expect_viol(vmask(IDX_ATOM_ORD));
    expect_first(IDX_ATOM_ORD);

    repeat (2) @(posedge clk);
    $display("Checks: %0d value checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Backstop in case a scenario stops advancing
  initial begin
    repeat (4000) @(posedge clk);
    $display("Simulation watchdog expired before the scenarios completed");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/core_trap_monitor.sv */
// Core trap monitor checking mepc on exceptions and OBI bus rules with sticky error flags
`timescale 1ns/1ps
`default_nettype none

module core_trap_monitor #(
  parameter bit          ATOMIC_EN = 1'b1,
  parameter int unsigned CNT_W     = 2
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  trap_pkg::wb_retire_t  wb_i,
  input  logic                  irq_ack_i,
  input  trap_pkg::cause_save_t cause_i,
  input  bus_pkg::instr_req_t   instr_i,
  input  bus_pkg::data_req_t    data_req_i,
  input  bus_pkg::data_rsp_t    data_rsp_i,
  output trap_pkg::viol_t       viol_o,
  output logic                  error_o,
  output trap_pkg::viol_idx_t   first_viol_o
);

  trap_pkg::trap_event_t  exp_evt;
  trap_pkg::trap_event_t  act_evt;
  trap_pkg::trap_record_t exp_rec;
  trap_pkg::trap_record_t act_rec;
  trap_pkg::viol_t        bus_viol;

  //////////////////////////////////////////////////////////////////////
  // Trap path
  //////////////////////////////////////////////////////////////////////

  trap_event_decoder trap_event_decoder_inst (
    .wb_i      (wb_i),
    .irq_ack_i (irq_ack_i),
    .cause_i   (cause_i),
    .exp_evt_o (exp_evt),
    .act_evt_o (act_evt)
  );

  // Expected addresses come from the retiring PC
  first_trap_capture exp_capture_inst (
    .clk    (clk),
    .rst_ni (rst_ni),
    .evt_i  (exp_evt),
    .rec_o  (exp_rec)
  );

  // Actual addresses come from the mepc write
  first_trap_capture act_capture_inst (
    .clk    (clk),
    .rst_ni (rst_ni),
    .evt_i  (act_evt),
    .rec_o  (act_rec)
  );

  // Bus path
  obi_bus_checker #(
    .ATOMIC_EN (ATOMIC_EN),
    .CNT_W     (CNT_W)
  ) obi_bus_checker_inst (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .instr_i    (instr_i),
    .data_req_i (data_req_i),
    .data_rsp_i (data_rsp_i),
    .viol_o     (bus_viol)
  );

  violation_reporter violation_reporter_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .exp_rec_i    (exp_rec),
    .act_rec_i    (act_rec),
    .bus_viol_i   (bus_viol),
    .viol_o       (viol_o),
    .error_o      (error_o),
    .first_viol_o (first_viol_o)
  );

endmodule

`default_nettype wire

/* verilog/violation_reporter.sv */
// Violation reporter comparing trap records and keeping sticky violation flags
`timescale 1ns/1ps
`default_nettype none

module violation_reporter (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  trap_pkg::trap_record_t exp_rec_i,
  input  trap_pkg::trap_record_t act_rec_i,
  input  trap_pkg::viol_t        bus_viol_i,
  output trap_pkg::viol_t        viol_o,
  output logic                   error_o,
  output trap_pkg::viol_idx_t    first_viol_o
);

  logic [trap_pkg::NUM_TRAP_KINDS-1:0] mismatch;
  trap_pkg::viol_t                     raise;
  logic [trap_pkg::VIOL_W-1:0]         raise_vec;
  logic [trap_pkg::VIOL_W-1:0]         viol_q;
  trap_pkg::viol_idx_t                 first_idx_d;
  trap_pkg::viol_idx_t                 first_idx_q;

  // A kind mismatches once both sides have seen it and the addresses differ
  always_comb begin
    for (int k = 0; k < trap_pkg::NUM_TRAP_KINDS; k++) begin
      mismatch[k] = exp_rec_i.found[k] & act_rec_i.found[k] &
                    (exp_rec_i.addr[k] != act_rec_i.addr[k]);
    end
  end

  // Bus pulses are merged with the mepc comparison into one raise vector
  always_comb begin
    raise               = bus_viol_i;
    raise.mepc_mismatch = bus_viol_i.mepc_mismatch | mismatch;
  end

  assign raise_vec = raise;

  // Lowest raised index wins when several bits go up together
  always_comb begin
    first_idx_d = '0;
    for (int i = trap_pkg::VIOL_W - 1; i >= 0; i--) begin
      if (raise_vec[i]) begin
        first_idx_d = trap_pkg::viol_idx_t'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q      <= '0;
      first_idx_q <= '0;
    end else begin
      viol_q <= viol_q | raise_vec;
      // The index is taken only on the edge where the first bit rises
      if ((viol_q == '0) && (raise_vec != '0)) begin
        first_idx_q <= first_idx_d;
      end
    end
  end

  assign viol_o       = viol_q;
  assign error_o      = |viol_q;
  assign first_viol_o = first_idx_q;

  // The reported first violation must be one of the sticky bits
  a_first_is_set : assert property (
    @(posedge clk) disable iff (!rst_ni)
    error_o |-> viol_q[first_idx_q]
  ) else $error("First violation index %0d points to a clear bit", first_idx_q);

endmodule

`default_nettype wire

/* verilog/obi_bus_checker.sv */
// OBI bus checker for fetch attributes, data attributes and outstanding transaction order
`timescale 1ns/1ps
`default_nettype none

module obi_bus_checker #(
  parameter bit          ATOMIC_EN = 1'b1,
  parameter int unsigned CNT_W     = 2
) (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  bus_pkg::instr_req_t  instr_i,
  input  bus_pkg::data_req_t   data_req_i,
  input  bus_pkg::data_rsp_t   data_rsp_i,
  output trap_pkg::viol_t      viol_o
);

  //////////////////////////////////////////////////////////////////////
  // Outstanding data transactions
  //////////////////////////////////////////////////////////////////////

  logic             cnt_up;
  logic             cnt_dn;
  logic             cnt_zero;
  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] cnt_q;

  // Address phase ends with the grant, response phase with rvalid
  assign cnt_up   = data_req_i.req & data_req_i.gnt;
  assign cnt_dn   = data_rsp_i.rvalid;
  assign cnt_zero = (cnt_q == '0);

  always_comb begin
    cnt_d = cnt_q;
    case ({cnt_up, cnt_dn})
      2'b10: cnt_d = cnt_q + CNT_W'(1);
      // A response with nothing outstanding is flagged and the count stays at zero
      2'b01: cnt_d = cnt_zero ? cnt_q : cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Attribute and ordering rules
  //////////////////////////////////////////////////////////////////////

  logic atomic_req;
  logic atomic_buf;
  logic atomic_ord;

  assign atomic_req = data_req_i.req & (|data_req_i.atop);

  if (ATOMIC_EN) begin : gen_atomic
    // Atomics need an empty pipeline and a non-bufferable region
    assign atomic_buf = atomic_req & data_req_i.memtype[bus_pkg::MEMTYPE_BUF_BIT];
    assign atomic_ord = (atomic_req & ~cnt_zero) | (data_rsp_i.rvalid & cnt_zero);
  end else begin : gen_no_atomic
    // Without atomic support any atomic request is illegal
    assign atomic_buf = 1'b0;
    assign atomic_ord = atomic_req;
  end

  always_comb begin
    viol_o                   = '0;
    viol_o.fetch_misaligned  = instr_i.req & (instr_i.addr[1:0] != 2'b00);
    viol_o.fetch_bufferable  = instr_i.req & instr_i.memtype[bus_pkg::MEMTYPE_BUF_BIT];
    viol_o.load_bufferable   = data_req_i.req & ~data_req_i.we &
                               data_req_i.memtype[bus_pkg::MEMTYPE_BUF_BIT];
    viol_o.atomic_bufferable = atomic_buf;
    viol_o.atomic_ordering   = atomic_ord;
  end

  // The core never has enough requests in flight to fill the counter
  a_cnt_below_max : assert property (
    @(posedge clk) disable iff (!rst_ni)
    cnt_q != {CNT_W{1'b1}}
  ) else $error("Outstanding counter reached its maximum value");

endmodule

`default_nettype wire

/* verilog/first_trap_capture.sv */
// First trap capture holding the earliest event address of every exception kind
`timescale 1ns/1ps
`default_nettype none

module first_trap_capture (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  trap_pkg::trap_event_t  evt_i,
  output trap_pkg::trap_record_t rec_o
);

  logic           [trap_pkg::NUM_TRAP_KINDS-1:0] found_q;
  trap_pkg::addr_t [trap_pkg::NUM_TRAP_KINDS-1:0] addr_q;
  logic                                          capture;

  // Only the first event of a kind is taken, later ones leave the record alone
  assign capture = evt_i.valid & ~found_q[evt_i.kind];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else if (capture) begin
      found_q[evt_i.kind] <= 1'b1;
    end
  end

  // Address storage follows the found flag of the same kind
  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q[evt_i.kind] <= evt_i.addr;
    end
  end

  assign rec_o.found = found_q;
  assign rec_o.addr  = addr_q;

  //////////////////////////////////////////////////////////////////////
  // Record stability
  //////////////////////////////////////////////////////////////////////

  // Once found, a kind keeps its flag and its address until reset
  for (genvar k = 0; k < trap_pkg::NUM_TRAP_KINDS; k++) begin : gen_hold_chk
    a_record_held : assert property (
      @(posedge clk) disable iff (!rst_ni)
      found_q[k] |=> (found_q[k] && $stable(addr_q[k]))
    ) else $error("Trap record of kind %0d changed after capture", k);
  end

endmodule

`default_nettype wire

/* verilog/trap_event_decoder.sv */
// Trap event decoder classifying retired instructions and cause saves into exception kinds
`timescale 1ns/1ps
`default_nettype none

module trap_event_decoder (
  input  trap_pkg::wb_retire_t  wb_i,
  input  logic                  irq_ack_i,
  input  trap_pkg::cause_save_t cause_i,
  output trap_pkg::trap_event_t exp_evt_o,
  output trap_pkg::trap_event_t act_evt_o
);

  //////////////////////////////////////////////////////////////////////
  // Expected side from the writeback stage
  //////////////////////////////////////////////////////////////////////

  logic wb_has_trap;

  // Any trap flag makes the retiring instruction an exception candidate
  assign wb_has_trap = wb_i.bus_err | wb_i.illegal | wb_i.ecall | wb_i.ebreak;

  always_comb begin
    exp_evt_o.valid = wb_i.valid & ~irq_ack_i & wb_has_trap;
    exp_evt_o.addr  = wb_i.pc;
    // A fetch fault wins over anything decoded from the faulty word
    if (wb_i.bus_err) begin
      exp_evt_o.kind = trap_pkg::KIND_INSTR_FAULT;
    end else if (wb_i.illegal) begin
      exp_evt_o.kind = trap_pkg::KIND_ILLEGAL;
    end else if (wb_i.ecall) begin
      exp_evt_o.kind = trap_pkg::KIND_ECALL;
    end else begin
      exp_evt_o.kind = trap_pkg::KIND_EBREAK;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Actual side from the cause save
  //////////////////////////////////////////////////////////////////////

  logic cause_known;

  always_comb begin
    cause_known    = 1'b1;
    act_evt_o.kind = trap_pkg::KIND_ILLEGAL;
    case (cause_i.code)
      trap_pkg::EXC_ILLEGAL:     act_evt_o.kind = trap_pkg::KIND_ILLEGAL;
      trap_pkg::EXC_ECALL_M:     act_evt_o.kind = trap_pkg::KIND_ECALL;
      trap_pkg::EXC_BREAKPOINT:  act_evt_o.kind = trap_pkg::KIND_EBREAK;
      trap_pkg::EXC_INSTR_FAULT: act_evt_o.kind = trap_pkg::KIND_INSTR_FAULT;
      default:                   cause_known = 1'b0;
    endcase
  end

  // Saves carrying the interrupt bit belong to interrupt entry and are skipped
  assign act_evt_o.valid = cause_i.save & ~cause_i.irq & cause_known;
  assign act_evt_o.addr  = cause_i.mepc;

endmodule

`default_nettype wire

/* verilog/bus_pkg.sv */
// OBI instruction and data bus observation types for the trap monitor
`default_nettype none

package bus_pkg;

  // OBI memtype attribute, bit 0 marks a bufferable access
  typedef logic [1:0] memtype_t;

  localparam int unsigned MEMTYPE_BUF_BIT = 0;

  // Width of the atomic operation code
  localparam int unsigned ATOP_W = 6;

  // Instruction fetch request as driven by the core
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    memtype_t    memtype;
  } instr_req_t;

  // Data request with the grant from the memory side
  // A nonzero atop marks an atomic access
  typedef struct packed {
    logic              req;
    logic              gnt;
    logic              we;
    logic [ATOP_W-1:0] atop;
    memtype_t          memtype;
  } data_req_t;

  // Data response phase
  typedef struct packed {
    logic rvalid;
  } data_rsp_t;

endpackage

`default_nettype wire

/* verilog/trap_pkg.sv */
// Trap monitor definitions for retire records, cause saves, trap events and violation flags
`default_nettype none

package trap_pkg;

  // Byte address as seen in PC and mepc
  typedef logic [31:0] addr_t;

  // Number of tracked exception kinds
  localparam int unsigned NUM_TRAP_KINDS = 4;

  // Exception kinds, also used as index into every per-kind vector
  typedef enum logic [1:0] {
    KIND_ILLEGAL     = 2'd0,
    KIND_ECALL       = 2'd1,
    KIND_EBREAK      = 2'd2,
    KIND_INSTR_FAULT = 2'd3
  } trap_kind_e;

  // Machine mode exception codes as written to mcause
  localparam logic [4:0] EXC_INSTR_FAULT = 5'd1;
  localparam logic [4:0] EXC_ILLEGAL     = 5'd2;
  localparam logic [4:0] EXC_BREAKPOINT  = 5'd3;
  localparam logic [4:0] EXC_ECALL_M     = 5'd11;

  // Instruction leaving writeback together with its trap flags
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  illegal;
    logic  ecall;
    logic  ebreak;
    logic  bus_err;
  } wb_retire_t;

  // Cause save strobe from the CSR file with the value written to mepc
  typedef struct packed {
    logic       save;
    logic       irq;
    logic [4:0] code;
    addr_t      mepc;
  } cause_save_t;

  // One classified trap observation
  typedef struct packed {
    logic       valid;
    trap_kind_e kind;
    addr_t      addr;
  } trap_event_t;

  // First observation of each kind
  typedef struct packed {
    logic  [NUM_TRAP_KINDS-1:0] found;
    addr_t [NUM_TRAP_KINDS-1:0] addr;
  } trap_record_t;

  // Violation flags, listed from the highest bit down
  // Bit index 0 to 3 is the mepc mismatch per kind, then 4 up to 8 for the bus rules
  typedef struct packed {
    logic                      atomic_ordering;
    logic                      atomic_bufferable;
    logic                      load_bufferable;
    logic                      fetch_bufferable;
    logic                      fetch_misaligned;
    logic [NUM_TRAP_KINDS-1:0] mepc_mismatch;
  } viol_t;

  localparam int unsigned VIOL_W = $bits(viol_t);

  // Index of a violation bit
  typedef logic [3:0] viol_idx_t;

endpackage

`default_nettype wire
